//--- source/mipsIsaPkg.sv
// ====================
// MIPS subset instruction set definitions
// opcodes, function codes, instruction fields and memory sizing
// ====================

package mipsIsaPkg;

  localparam int memWords    = 128;  // words per memory bank
  localparam int memAddrBits = 7;    // word index width into a bank
  localparam logic [4:0] linkReg = 5'd31;  // jal return register

  // primary opcodes, bits 31:26
  typedef enum logic [5:0] {
    opRtype = 6'h00,
    opJ     = 6'h02,
    opJal   = 6'h03,
    opBeq   = 6'h04,
    opAddi  = 6'h08,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeT;

  // R-type function codes, bits 5:0
  typedef enum logic [5:0] {
    fnSll = 6'h00,
    fnSrl = 6'h02,
    fnJr  = 6'h08,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } functT;

  // immediate is [15:0], jump target is [25:0]
  typedef struct packed {
    opcodeT     opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    functT      funct;
  } instrT;

endpackage

//--- source/mipsCtrlPkg.sv
// ====================
// control definitions for the single-cycle core
// ALU operations, decoded controls, write-back record
// ====================

package mipsCtrlPkg;

  typedef enum logic [3:0] {
    aluAdd  = 4'd0,
    aluSub  = 4'd1,
    aluAnd  = 4'd2,
    aluOr   = 4'd3,
    aluSlt  = 4'd4,
    aluSll  = 4'd5,
    aluSrl  = 4'd6,
    aluPass = 4'd7   // forwards operand b
  } aluOpT;

  typedef struct packed {
    logic  regDst;    // write rd instead of rt
    logic  aluSrc;    // b from sign-extended immediate
    logic  memToReg;  // write back load data
    logic  regWrite;
    logic  memWrite;
    logic  branch;    // beq
    logic  jump;      // j, jal
    logic  jumpReg;   // jr
    logic  link;      // jal writes pc+4 to r31
    logic  shiftSel;  // shamt feeds the ALU
    aluOpT aluOp;
  } ctrlT;

  // one register write-back as seen outside
  typedef struct packed {
    logic        en;
    logic [4:0]  regAddr;
    logic [31:0] data;
  } wbT;

endpackage

//--- source/mipsDecoder.sv
// ====================
// main control plus ALU control
// instruction word in, decoded control struct out
// ====================
`timescale 1ns/100ps

module mipsDecoder (
  input  mipsIsaPkg::instrT instr,
  output mipsCtrlPkg::ctrlT ctrl
);
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;

  always_comb begin
    ctrl       = '0;  // inactive unless recognised
    ctrl.aluOp = aluPass;
    case (instr.opcode)
      opRtype: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (instr.funct)
          fnAdd: ctrl.aluOp = aluAdd;
          fnSub: ctrl.aluOp = aluSub;
          fnAnd: ctrl.aluOp = aluAnd;
          fnOr:  ctrl.aluOp = aluOr;
          fnSlt: ctrl.aluOp = aluSlt;
          fnSll: begin
            ctrl.aluOp    = aluSll;
            ctrl.shiftSel = 1'b1;
          end
          fnSrl: begin
            ctrl.aluOp    = aluSrl;
            ctrl.shiftSel = 1'b1;
          end
          fnJr: begin
            ctrl.regDst   = 1'b0;
            ctrl.regWrite = 1'b0;  // jr writes nothing
            ctrl.jumpReg  = 1'b1;
          end
          default: begin
            ctrl.regDst   = 1'b0;  // unknown funct writes nothing
            ctrl.regWrite = 1'b0;
          end
        endcase
      end
      opAddi: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluAdd;  // base + offset
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end
      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;  // zero flag on equal
      end
      opJ:   ctrl.jump = 1'b1;
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ;  // stays inactive
    endcase
  end

endmodule

//--- source/mipsAlu.sv
// ====================
// 32-bit ALU with zero flag
// ====================
`timescale 1ns/100ps

module mipsAlu (
  input  logic [31:0]        a,
  input  logic [31:0]        b,
  input  logic [4:0]         shamt,
  input  mipsCtrlPkg::aluOpT op,
  output logic [31:0]        result,
  output logic               zero
);
  import mipsCtrlPkg::*;

  always_comb begin
    case (op)
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluSlt:  result = {31'd0, $signed(a) < $signed(b)};  // two's complement compare
      aluSll:  result = b << shamt;
      aluSrl:  result = b >> shamt;  // logical shift with zero fill
      aluPass: result = b;
      default: result = '0;
    endcase
  end

  assign zero = (result == 32'd0);  // beq taken when a == b

endmodule

//--- source/mipsRegFile.sv
// ====================
// register file, 31 writable regs and a hardwired zero
// two combinational reads, one clocked write
// ====================
`timescale 1ns/100ps

module mipsRegFile (
  input  logic        clk,
  input  logic        we,
  input  logic [4:0]  rdAddrA,
  input  logic [4:0]  rdAddrB,
  input  logic [4:0]  wrAddr,
  input  logic [31:0] wrData,
  output logic [31:0] rdDataA,
  output logic [31:0] rdDataB
);

  logic [31:0] regs [1:31];  // no storage for r0

  always_ff @(posedge clk) begin
    if (we && wrAddr != 5'd0) begin
      regs[wrAddr] <= wrData;
    end
  end

  // r0 reads as zero
  assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : regs[rdAddrB];

endmodule

//--- source/mipsCore.sv
// ====================
// single-cycle MIPS core
// pc, next-pc select, operand and write-back muxing
// all state changes gated by run
// ====================
`timescale 1ns/100ps

module mipsCore (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             run,
  output logic [mipsIsaPkg::memAddrBits-1:0] instrAddr,
  input  logic [31:0]                      instr,
  output logic [mipsIsaPkg::memAddrBits-1:0] dataAddr,
  output logic [31:0]                      storeData,
  output logic                             storeEn,
  input  logic [31:0]                      loadData,
  output mipsCtrlPkg::wbT                  wb
);
  import mipsIsaPkg::*;
  import mipsCtrlPkg::*;

  // ==================== fetch / decode
  logic [31:0] pc;
  logic [31:0] pcNext;
  logic [31:0] pcPlus4;
  instrT       ins;
  ctrlT        ctrl;

  assign ins       = instr;
  assign instrAddr = pc[memAddrBits+1:2];  // word index
  assign pcPlus4   = pc + 32'd4;

  mipsDecoder uDecoder (
    .instr (ins),
    .ctrl  (ctrl)
  );

  // ==================== execute
  logic [31:0] rdDataA, rdDataB;
  logic [31:0] signExt;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;
  logic [4:0]  wrAddr;
  logic [31:0] wrData;
  logic        regWe;

  assign signExt = {{16{ins[15]}}, ins[15:0]};
  assign aluB    = ctrl.aluSrc ? signExt : rdDataB;

  mipsAlu uAlu (
    .a      (rdDataA),
    .b      (aluB),
    .shamt  (ctrl.shiftSel ? ins.shamt : 5'd0),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // write register is r31 for jal, rd for R-type, else rt
  assign wrAddr = ctrl.link ? linkReg : (ctrl.regDst ? ins.rd : ins.rt);
  assign wrData = ctrl.link ? pcPlus4 : (ctrl.memToReg ? loadData : aluResult);
  assign regWe  = ctrl.regWrite & run;

  mipsRegFile uRegFile (
    .clk     (clk),
    .we      (regWe),
    .rdAddrA (ins.rs),
    .rdAddrB (ins.rt),
    .wrAddr  (wrAddr),
    .wrData  (wrData),
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  // data memory side
  assign dataAddr  = aluResult[memAddrBits+1:2];
  assign storeData = rdDataB;
  assign storeEn   = ctrl.memWrite & run;

  // write-back seen outside with r0 writes hidden
  assign wb.en      = regWe & (wrAddr != 5'd0);
  assign wb.regAddr = wrAddr;
  assign wb.data    = wrData;

  // ==================== next pc
  always_comb begin
    if (ctrl.jumpReg) begin
      pcNext = rdDataA;  // jr
    end else if (ctrl.jump) begin
      pcNext = {pcPlus4[31:28], ins[25:0], 2'b00};
    end else if (ctrl.branch && aluZero) begin
      pcNext = pcPlus4 + {signExt[29:0], 2'b00};
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= 32'd0;
    end else if (run) begin
      pc <= pcNext;  // holds while run is low
    end
  end

endmodule

//--- source/mipsMemory.sv
// ====================
// instruction and data banks
// async reads, clocked writes, program load port
// ====================
`timescale 1ns/100ps

module mipsMemory (
  input  logic                             clk,
  input  logic                             progWe,
  input  logic [mipsIsaPkg::memAddrBits-1:0] progAddr,
  input  logic [31:0]                      progData,
  input  logic [mipsIsaPkg::memAddrBits-1:0] instrAddr,
  output logic [31:0]                      instr,
  input  logic [mipsIsaPkg::memAddrBits-1:0] dataAddr,
  input  logic [31:0]                      storeData,
  input  logic                             storeEn,
  output logic [31:0]                      loadData
);
  import mipsIsaPkg::*;

  logic [31:0] instrBank [memWords];
  logic [31:0] dataBank  [memWords];

  // instruction bank written only by the load port
  always_ff @(posedge clk) begin
    if (progWe) begin
      instrBank[progAddr] <= progData;
    end
  end

  // data bank written by sw from the core
  always_ff @(posedge clk) begin
    if (storeEn) begin
      dataBank[dataAddr] <= storeData;
    end
  end

  assign instr    = instrBank[instrAddr];
  assign loadData = dataBank[dataAddr];  // lw settles in the same cycle

endmodule

//--- source/mipsSystem.sv
// ====================
// top level, core plus memories
// ====================
`timescale 1ns/100ps

module mipsSystem (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             run,
  input  logic                             progWe,
  input  logic [mipsIsaPkg::memAddrBits-1:0] progAddr,
  input  logic [31:0]                      progData,
  output mipsCtrlPkg::wbT                  wb
);
  import mipsIsaPkg::*;

  logic [memAddrBits-1:0] instrAddr;
  logic [memAddrBits-1:0] dataAddr;
  logic [31:0]            instr;
  logic [31:0]            storeData;
  logic [31:0]            loadData;
  logic                   storeEn;

  mipsCore uCore (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .instrAddr (instrAddr),
    .instr     (instr),
    .dataAddr  (dataAddr),
    .storeData (storeData),
    .storeEn   (storeEn),
    .loadData  (loadData),
    .wb        (wb)
  );

  mipsMemory uMemory (
    .clk       (clk),
    .progWe    (progWe),
    .progAddr  (progAddr),
    .progData  (progData),
    .instrAddr (instrAddr),
    .instr     (instr),
    .dataAddr  (dataAddr),
    .storeData (storeData),
    .storeEn   (storeEn),
    .loadData  (loadData)
  );

endmodule

//--- bench/mipsCore_assertions.sv
// ====================
// concurrent checks on the single-cycle core
// bound into every mipsCore instance
// ====================
`timescale 1ns/100ps

module mipsCoreAssertions (
  input logic            clk,
  input logic            rst,
  input logic            run,
  input logic [31:0]     pc,
  input logic            storeEn,
  input mipsCtrlPkg::wbT wb
);

  // pc cleared by reset
  pcAfterReset: assert property (@(posedge clk) rst |=> (pc == 32'd0))
    else $error("pc not zero one cycle after reset");

  // no state change while halted
  quietWhenHalted: assert property (@(posedge clk) disable iff (rst)
    !run |-> (!storeEn && !wb.en))
    else $error("store or write-back strobe while run is low");

  noZeroRegWb: assert property (@(posedge clk) disable iff (rst)
    wb.en |-> (wb.regAddr != 5'd0))
    else $error("write-back shown for register 0");

  pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc lost word alignment");

endmodule

bind mipsCore mipsCoreAssertions uAssertions (
  .clk     (clk),
  .rst     (rst),
  .run     (run),
  .pc      (pc),
  .storeEn (storeEn),
  .wb      (wb)
);

//--- bench/mipsChecker.sv
// ====================
// write-back checker
// compares each wb strobe with the expected list
// prints one line per test and a closing summary
// ====================
`timescale 1ns/100ps

module mipsChecker #(
  parameter int maxExp     = 64,
  parameter int maxTests   = 8,
  parameter int quietEdges = 4
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            run,
  input  mipsCtrlPkg::wbT wb,
  input  logic [4:0]      expReg   [maxExp],
  input  logic [31:0]     expData  [maxExp],
  input  logic [7:0]      expTest  [maxExp],
  input  logic [127:0]    testName [maxTests],
  input  int              expCount,
  output logic            done,
  output int              errors
);

  int idx;         // next expected entry
  int testChecks;
  int testErrors;
  int testsOk;
  int testsBad;
  int tail;        // edges watched after the last entry

  task automatic reportTest(input logic [7:0] testIdx);
    $display("test %0s: %0d write-backs, %0d mismatches, %s",
             testName[testIdx], testChecks, testErrors, (testErrors == 0) ? "ok" : "bad");
    if (testErrors == 0) testsOk++;
    else testsBad++;
    testChecks = 0;
    testErrors = 0;
  endtask

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      idx        = 0;
      testChecks = 0;
      testErrors = 0;
      testsOk    = 0;
      testsBad   = 0;
      tail       = 0;
      errors     = 0;
      done      <= 1'b0;
    end else begin
      if (wb.en && !run) begin
        $display("write-back to r%0d at time %0t although run is low", wb.regAddr, $time);
        errors++;
      end else if (wb.en && idx >= expCount) begin
        $display("unexpected write-back to r%0d at time %0t, expected list used up",
                 wb.regAddr, $time);
        errors++;
      end else if (wb.en) begin
        testChecks++;
        if (wb.regAddr !== expReg[idx]) begin
          $display("** Error at time %0t: wb.regAddr expected %0d got %0d",
                   $time, expReg[idx], wb.regAddr);
          testErrors++;
          errors++;
        end
        if (wb.data !== expData[idx]) begin
          $display("** Error at time %0t: wb.data expected %08h got %08h",
                   $time, expData[idx], wb.data);
          testErrors++;
          errors++;
        end
        // last entry of this test group
        if (idx + 1 == expCount || expTest[idx + 1] != expTest[idx]) begin
          reportTest(expTest[idx]);
        end
        idx++;
      end
      // self loop at the end must stay silent
      if (idx == expCount && tail <= quietEdges) begin
        if (tail == quietEdges) begin
          $display("summary: %0d tests ok, %0d tests bad, %0d write-backs, %0d errors",
                   testsOk, testsBad, expCount, errors);
          done <= 1'b1;
        end
        tail++;
      end
    end
  end

endmodule

//--- bench/mipsBench.sv
// ====================
// testbench top for the MIPS subset system
// reads the pattern file, loads the program, runs it
// ====================
`timescale 1ns/100ps

module mipsBench;
  import mipsIsaPkg::*;

  localparam int    maxExp      = 64;
  localparam int    maxTests    = 8;
  localparam int    runTimeout  = 2000;  // cycles for the whole program
  localparam string patternFile = "bench/mipsPatterns.txt";

  logic                   clk;
  logic                   rst;
  logic                   run;
  logic                   progWe;
  logic [memAddrBits-1:0] progAddr;
  logic [31:0]            progData;
  mipsCtrlPkg::wbT        wb;

  // ==================== pattern storage
  logic [31:0]  progWords [memWords];
  logic [4:0]   expReg    [maxExp];
  logic [31:0]  expData   [maxExp];
  logic [7:0]   expTest   [maxExp];  // test group of each entry
  logic [127:0] testName  [maxTests];
  int           progCount;
  int           expCount;
  int           testCount;
  int           benchErrors;
  logic         checkDone;
  int           checkErrors;

  always #2 clk = ~clk;  // 4 ns period

  mipsSystem DUT (
    .clk      (clk),
    .rst      (rst),
    .run      (run),
    .progWe   (progWe),
    .progAddr (progAddr),
    .progData (progData),
    .wb       (wb)
  );

  mipsChecker #(.maxExp(maxExp), .maxTests(maxTests)) uChecker (
    .clk      (clk),
    .rst      (rst),
    .run      (run),
    .wb       (wb),
    .expReg   (expReg),
    .expData  (expData),
    .expTest  (expTest),
    .testName (testName),
    .expCount (expCount),
    .done     (checkDone),
    .errors   (checkErrors)
  );

  // reads T name, I word and E reg value lines and skips the rest
  task automatic readPatterns(output bit ok);
    int           fd;
    int           n;
    int           regNum;
    string        line;
    logic [127:0] name;
    logic [31:0]  value;
    fd = $fopen(patternFile, "r");
    if (fd == 0) begin
      $display("cannot open pattern file %s", patternFile);
      benchErrors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        name = '0;
        n = $fgets(line, fd);
        if (line.len() == 0) continue;
        case (line.getc(0))
          "T": begin
            n = $sscanf(line, "T %s", name);
            if (n != 1 || testCount >= maxTests) begin
              $display("bad or surplus test header: %s", line);
              benchErrors++;
            end else begin
              testName[testCount] = name;
              testCount++;
            end
          end
          "I": begin
            n = $sscanf(line, "I %h", value);
            if (n != 1 || progCount >= memWords) begin
              $display("bad or surplus program word: %s", line);
              benchErrors++;
            end else begin
              progWords[progCount] = value;
              progCount++;
            end
          end
          "E": begin
            n = $sscanf(line, "E %d %h", regNum, value);
            if (n != 2 || testCount == 0 || expCount >= maxExp) begin
              $display("bad or misplaced expected entry: %s", line);
              benchErrors++;
            end else begin
              expReg[expCount]  = regNum[4:0];
              expData[expCount] = value;
              expTest[expCount] = 8'(testCount - 1);
              expCount++;
            end
          end
          default: ;  // comments, blank lines
        endcase
      end
      $fclose(fd);
      if (progCount == 0 || expCount == 0) begin
        $display("pattern file holds no program or no expected write-backs");
        benchErrors++;
      end
    end
    ok = (benchErrors == 0);
  endtask

  // one word per cycle through the load port
  task automatic loadProgram();
    for (int i = 0; i < progCount; i++) begin
      @(posedge clk);
      progWe   <= 1'b1;
      progAddr <= memAddrBits'(i);
      progData <= progWords[i];
    end
    @(posedge clk);
    progWe <= 1'b0;
  endtask

  // polled on the falling edge so the checker has settled
  task automatic waitForChecker(output bit timedOut);
    int cycles;
    cycles   = 0;
    timedOut = 1'b0;
    while (!checkDone && cycles < runTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!checkDone) begin
      $display("timeout: program stalled, expected write-backs missing after %0d cycles",
               runTimeout);
      timedOut = 1'b1;
    end
  endtask

  task automatic endRun(input bit failed);
    if (failed || benchErrors != 0 || checkErrors != 0) begin
      $display("Result: FAILED");
    end else begin
      $display("Result: PASSED");
    end
    $finish;
  endtask

  initial begin : mainFlow
    bit ok;
    bit timedOut;
    clk         = 1'b0;
    rst         = 1'b1;
    run         = 1'b0;
    progWe      = 1'b0;
    progAddr    = '0;
    progData    = '0;
    progCount   = 0;
    expCount    = 0;
    testCount   = 0;
    benchErrors = 0;
    readPatterns(ok);
    if (!ok) begin
      endRun(1'b1);
    end else begin
      repeat (4) @(posedge clk);  // reset held 4 cycles
      rst <= 1'b0;
      loadProgram();              // run still low
      @(posedge clk);
      run <= 1'b1;
      waitForChecker(timedOut);
      endRun(timedOut);
    end
  end

endmodule

//--- bench/mipsPatterns.txt
# T <name> opens a test, I <hex> is the next program word from address 0 on,
# E <reg> <hex> is the next expected write-back (register number, value)
T arith
I 20010005  # addi r1, r0, 5
E 1 00000005
I 2002FFFD  # addi r2, r0, -3
E 2 FFFFFFFD
I 00221820  # add r3, r1, r2
E 3 00000002
I 00412022  # sub r4, r2, r1
E 4 FFFFFFF8
I 00442824  # and r5, r2, r4
E 5 FFFFFFF8
I 00233025  # or r6, r1, r3
E 6 00000007
I 0041382A  # slt r7, r2, r1
E 7 00000001
I 0022402A  # slt r8, r1, r2
E 8 00000000
T shift
I 00014900  # sll r9, r1, 4
E 9 00000050
I 00025702  # srl r10, r2, 28
E 10 0000000F
I 20200064  # addi r0, r1, 100
I 00015820  # add r11, r0, r1
E 11 00000005
I 00006025  # or r12, r0, r0
E 12 00000000
T memory
I AC060008  # sw r6, 8(r0)
I AC04000C  # sw r4, 12(r0)
I 8C0D0008  # lw r13, 8(r0)
E 13 00000007
I 200F0008  # addi r15, r0, 8
E 15 00000008
I 8DEE0004  # lw r14, 4(r15)
E 14 FFFFFFF8
I ADE10000  # sw r1, 0(r15)
I 8DF00000  # lw r16, 0(r15)
E 16 00000005
T branch
I 102B0001  # beq r1, r11, +1 taken
I 20120001  # addi r18, r0, 1 skipped
I 20120002  # addi r18, r0, 2
E 18 00000002
I 10220001  # beq r1, r2, +1 not taken
I 20130003  # addi r19, r0, 3
E 19 00000003
I 0800001B  # j 108
I 20140004  # addi r20, r0, 4 skipped
I 20140005  # addi r20, r0, 5
E 20 00000005
T call
I 0C00001F  # jal 124
E 31 00000074
I 20150007  # addi r21, r0, 7 after return
I 0800001E  # j 120 self loop
I 20160006  # addi r22, r0, 6
E 22 00000006
I 03E00008  # jr r31
E 21 00000007

//--- vlog.f
source/mipsIsaPkg.sv
source/mipsCtrlPkg.sv
source/mipsDecoder.sv
source/mipsAlu.sv
source/mipsRegFile.sv
source/mipsCore.sv
source/mipsMemory.sv
source/mipsSystem.sv
bench/mipsCore_assertions.sv
bench/mipsChecker.sv
bench/mipsBench.sv

//--- run.sh
#!/bin/sh
# build and run the MIPS subset testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mipsBench -f vlog.f

status=0
./obj_dir/VmipsBench > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi
echo "simulation finished without failures"
